//--- Bender.yml
package:
  name: content_scanner

sources:
  - files:
      - source/scan_pkg.sv
      - source/dfa_gopher.sv
      - source/dfa_finger.sv
      - source/category_counter.sv
      - source/content_scanner_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/scanner_checker.sv
      - verification/scanner_tb.sv

//--- source/category_counter.sv
`timescale 1ns/1ps

module category_counter #(
  // 0 picks the gopher DFA, 1 the finger DFA
  parameter int unsigned CATEGORY = 0,
  parameter int unsigned STREAM_W = 6
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load_state,
  input  logic                new_stream_id,
  input  logic [STREAM_W-1:0] stream_id,
  input  scan_pkg::char_t     char_in,
  input  logic                char_in_vld,
  input  logic                eop,
  input  logic                enable,
  output scan_pkg::count_t    count,
  output logic                fired
);

  localparam int unsigned STREAMS = 1 << STREAM_W;

  // Saved DFA state per stream
  scan_pkg::dfa_state_t state_mem [0:STREAMS-1];

  // Restore value and strobe, one cycle after load_state
  scan_pkg::dfa_state_t restore_state;
  logic                 restore_vld;

  // DFA input stage
  scan_pkg::char_t      char_r;
  logic                 char_vld_r;
  scan_pkg::dfa_state_t restore_state_r;
  logic                 restore_vld_r;

  // DFA outputs, raw and registered
  scan_pkg::dfa_state_t dfa_state;
  logic                 dfa_accept;
  scan_pkg::dfa_state_t dfa_state_r;
  logic                 dfa_accept_r;

  // Strobe follows load_state by one cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      restore_vld <= 1'b0;
    else
      restore_vld <= load_state;
  end

  // Fresh streams start from zero, others pick up the saved state
  always_ff @(posedge clk)
  begin
    if (load_state)
      restore_state <= new_stream_id ? scan_pkg::DFA_START : state_mem[stream_id];
  end

  // Save only for enabled packets
  always_ff @(posedge clk)
  begin
    if (eop && enable)
      state_mem[stream_id] <= dfa_state_r;
  end

  // Register stage around the DFA
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r    <= 1'b0;
      restore_vld_r <= 1'b0;
      dfa_accept_r  <= 1'b0;
    end
    else
    begin
      char_vld_r    <= char_in_vld;
      restore_vld_r <= restore_vld;
      dfa_accept_r  <= dfa_accept;
    end
  end

  // Byte and state registers of the DFA stage
  always_ff @(posedge clk)
  begin
    char_r          <= char_in;
    restore_state_r <= restore_state;
    dfa_state_r     <= dfa_state;
  end

  // Match flag and packet counter
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count <= '0;
      fired <= 1'b0;
    end
    else
    begin
      // Flag is cleared at packet start, then set by any accept
      if (load_state)
        fired <= 1'b0;
      else if (eop && !enable)
        fired <= 1'b0;
      else if (dfa_accept_r)
        fired <= 1'b1;
      // At most one count per packet
      if (eop && enable)
        count <= count + scan_pkg::count_t'(fired);
    end
  end

  generate
    if (CATEGORY == 0)
    begin : gen_gopher
      dfa_gopher u_dfa (
        .clk          (clk),
        .rst_n        (rst_n),
        .char_in      (char_r),
        .char_vld     (char_vld_r),
        .state_in     (restore_state_r),
        .state_in_vld (restore_vld_r),
        .state_out    (dfa_state),
        .accept_out   (dfa_accept)
      );
    end
    else
    begin : gen_finger
      dfa_finger u_dfa (
        .clk          (clk),
        .rst_n        (rst_n),
        .char_in      (char_r),
        .char_vld     (char_vld_r),
        .state_in     (restore_state_r),
        .state_in_vld (restore_vld_r),
        .state_out    (dfa_state),
        .accept_out   (dfa_accept)
      );
    end
  endgenerate

endmodule

//--- source/content_scanner_top.sv
`timescale 1ns/1ps

module content_scanner_top #(
  // Stream number width, 64 streams by default
  parameter int unsigned STREAM_W = 6
) (
  input  logic                clk,
  input  logic                rst_n,
  // Packet start and stream context
  input  logic                load_state,
  input  logic                new_stream_id,
  input  logic [STREAM_W-1:0] stream_id,
  // Payload bytes
  input  scan_pkg::char_t     char_in,
  input  logic                char_in_vld,
  // Packet end and per-category enable
  input  logic                eop,
  input  logic [1:0]          enable,
  output scan_pkg::count_t    count_gopher,
  output scan_pkg::count_t    count_finger,
  output logic [1:0]          fired
);

  // Bit 0 is the gopher category
  category_counter #(
    .CATEGORY (0),
    .STREAM_W (STREAM_W)
  ) u_gopher (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .eop           (eop),
    .enable        (enable[0]),
    .count         (count_gopher),
    .fired         (fired[0])
  );

  // Bit 1 is the finger category
  category_counter #(
    .CATEGORY (1),
    .STREAM_W (STREAM_W)
  ) u_finger (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .eop           (eop),
    .enable        (enable[1]),
    .count         (count_finger),
    .fired         (fired[1])
  );

endmodule

//--- source/dfa_finger.sv
`timescale 1ns/1ps

module dfa_finger (
  input  logic                 clk,
  input  logic                 rst_n,
  input  scan_pkg::char_t      char_in,
  input  logic                 char_vld,
  input  scan_pkg::dfa_state_t state_in,
  input  logic                 state_in_vld,
  output scan_pkg::dfa_state_t state_out,
  output logic                 accept_out
);

  // One state per matched prefix of "finger"
  typedef enum logic [scan_pkg::STATE_W-1:0] {
    ST_START  = scan_pkg::DFA_START,
    ST_F      = scan_pkg::FINGER_F,
    ST_FI     = scan_pkg::FINGER_FI,
    ST_FIN    = scan_pkg::FINGER_FIN,
    ST_FING   = scan_pkg::FINGER_FING,
    ST_FINGE  = scan_pkg::FINGER_FINGE,
    ST_FINGER = scan_pkg::FINGER_ACCEPT
  } finger_state_t;

  finger_state_t state_q;
  finger_state_t cur_state;
  finger_state_t nxt_state;

  function automatic finger_state_t step(input finger_state_t cur, input scan_pkg::char_t c);
    finger_state_t nxt;
    // No self-overlap, only an f restarts the keyword
    nxt = (c == "f") ? ST_F : ST_START;
    case (cur)
      ST_F:     if (c == "i") nxt = ST_FI;
      ST_FI:    if (c == "n") nxt = ST_FIN;
      ST_FIN:   if (c == "g") nxt = ST_FING;
      ST_FING:  if (c == "e") nxt = ST_FINGE;
      ST_FINGE: if (c == "r") nxt = ST_FINGER;
      default: ;
    endcase
    return nxt;
  endfunction

  // Pick the restored state when the wrapper supplies one
  always_comb
  begin
    cur_state = state_in_vld ? finger_state_t'(state_in) : state_q;
    nxt_state = step(cur_state, char_in);
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q    <= ST_START;
      accept_out <= 1'b0;
    end
    else if (char_vld)
    begin
      state_q    <= nxt_state;
      accept_out <= (nxt_state == ST_FINGER);
    end
    else
    begin
      if (state_in_vld)
        state_q <= finger_state_t'(state_in);
      accept_out <= 1'b0;
    end
  end

  assign state_out = state_q;

endmodule

//--- source/dfa_gopher.sv
`timescale 1ns/1ps

module dfa_gopher (
  input  logic                 clk,
  input  logic                 rst_n,
  input  scan_pkg::char_t      char_in,
  input  logic                 char_vld,
  input  scan_pkg::dfa_state_t state_in,
  input  logic                 state_in_vld,
  output scan_pkg::dfa_state_t state_out,
  output logic                 accept_out
);

  // One state per matched prefix of "gopher"
  typedef enum logic [scan_pkg::STATE_W-1:0] {
    ST_START  = scan_pkg::DFA_START,
    ST_G      = scan_pkg::GOPHER_G,
    ST_GO     = scan_pkg::GOPHER_GO,
    ST_GOP    = scan_pkg::GOPHER_GOP,
    ST_GOPH   = scan_pkg::GOPHER_GOPH,
    ST_GOPHE  = scan_pkg::GOPHER_GOPHE,
    ST_GOPHER = scan_pkg::GOPHER_ACCEPT
  } gopher_state_t;

  gopher_state_t state_q;
  gopher_state_t cur_state;
  gopher_state_t nxt_state;

  // One byte step of the matcher
  function automatic gopher_state_t step(input gopher_state_t cur, input scan_pkg::char_t c);
    gopher_state_t nxt;
    // Mismatch falls back to start, or to "g" when the byte is a g
    nxt = (c == "g") ? ST_G : ST_START;
    case (cur)
      ST_G:     if (c == "o") nxt = ST_GO;
      ST_GO:    if (c == "p") nxt = ST_GOP;
      ST_GOP:   if (c == "h") nxt = ST_GOPH;
      ST_GOPH:  if (c == "e") nxt = ST_GOPHE;
      ST_GOPHE: if (c == "r") nxt = ST_GOPHER;
      // Start, accept and unknown codes keep the fallback
      default: ;
    endcase
    return nxt;
  endfunction

  // Restored state overrides the held one for this byte
  always_comb
  begin
    cur_state = state_in_vld ? gopher_state_t'(state_in) : state_q;
    nxt_state = step(cur_state, char_in);
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q    <= ST_START;
      accept_out <= 1'b0;
    end
    else if (char_vld)
    begin
      state_q    <= nxt_state;
      // One pulse per completed keyword
      accept_out <= (nxt_state == ST_GOPHER);
    end
    else
    begin
      // Restore without a byte just loads the state
      if (state_in_vld)
        state_q <= gopher_state_t'(state_in);
      accept_out <= 1'b0;
    end
  end

  assign state_out = state_q;

endmodule

//--- source/scan_pkg.sv
package scan_pkg;

  // One payload byte
  typedef logic [7:0] char_t;

  // State code width, the same for every category
  // so one state memory layout serves all of them
  localparam int unsigned STATE_W = 11;
  typedef logic [STATE_W-1:0] dfa_state_t;

  // Per-category packet counter
  localparam int unsigned COUNT_W = 16;
  typedef logic [COUNT_W-1:0] count_t;

  // Code zero is the start state of every DFA
  localparam dfa_state_t DFA_START = dfa_state_t'(0);

  // Progress codes for "gopher"
  localparam dfa_state_t GOPHER_G      = dfa_state_t'(1);
  localparam dfa_state_t GOPHER_GO     = dfa_state_t'(2);
  localparam dfa_state_t GOPHER_GOP    = dfa_state_t'(3);
  localparam dfa_state_t GOPHER_GOPH   = dfa_state_t'(4);
  localparam dfa_state_t GOPHER_GOPHE  = dfa_state_t'(5);
  // Whole keyword seen
  localparam dfa_state_t GOPHER_ACCEPT = dfa_state_t'(6);

  // Progress codes for "finger"
  localparam dfa_state_t FINGER_F      = dfa_state_t'(1);
  localparam dfa_state_t FINGER_FI     = dfa_state_t'(2);
  localparam dfa_state_t FINGER_FIN    = dfa_state_t'(3);
  localparam dfa_state_t FINGER_FING   = dfa_state_t'(4);
  localparam dfa_state_t FINGER_FINGE  = dfa_state_t'(5);
  // Whole keyword seen
  localparam dfa_state_t FINGER_ACCEPT = dfa_state_t'(6);

endpackage

//--- sources.f
source/scan_pkg.sv
source/dfa_gopher.sv
source/dfa_finger.sv
source/category_counter.sv
source/content_scanner_top.sv
verification/tb_clock_gen.sv
verification/scanner_checker.sv
verification/scanner_tb.sv

//--- verification/scanner_checker.sv
`timescale 1ns/1ps

module scanner_checker (
  input logic             clk,
  input logic             rst_n,
  input logic             load_state,
  input logic             eop,
  input logic [1:0]       enable,
  input scan_pkg::count_t count_gopher,
  input scan_pkg::count_t count_finger,
  input logic [1:0]       fired
);

  // Count of failed assertions
  int unsigned error_count = 0;

  // Match flags start every packet cleared
  a_fired_clear: assert property (@(posedge clk) disable iff (!rst_n)
    load_state |=> (fired == 2'b00))
  else
  begin
    $error("fired not cleared after load_state");
    error_count++;
  end

  // Counts move one step, and only right after eop
  a_gopher_step: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(count_gopher) |-> $past(eop) && (count_gopher == $past(count_gopher) + 16'd1))
  else
  begin
    $error("count_gopher changed outside eop or by more than one");
    error_count++;
  end

  a_finger_step: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(count_finger) |-> $past(eop) && (count_finger == $past(count_finger) + 16'd1))
  else
  begin
    $error("count_finger changed outside eop or by more than one");
    error_count++;
  end

  // Disabled category holds its count
  a_gopher_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    (eop && !enable[0]) |=> $stable(count_gopher))
  else
  begin
    $error("count_gopher moved while its enable was low");
    error_count++;
  end

  a_finger_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    (eop && !enable[1]) |=> $stable(count_finger))
  else
  begin
    $error("count_finger moved while its enable was low");
    error_count++;
  end

  // Synchronous reset clears both counters
  a_reset_counts: assert property (@(posedge clk)
    !rst_n |=> (count_gopher == '0) && (count_finger == '0))
  else
  begin
    $error("counts not zero during reset");
    error_count++;
  end

endmodule

//--- verification/scanner_tb.sv
`timescale 1ns/1ps

module scanner_tb;

  localparam int unsigned STREAM_W = 6;
  localparam int RAND_PACKETS = 64;
  // About twice the cycles that all packets take
  localparam int TIMEOUT_CYCLES = 4000;

  logic                clk;
  logic                rst_n;
  logic                load_state;
  logic                new_stream_id;
  logic [STREAM_W-1:0] stream_id;
  scan_pkg::char_t     char_in;
  logic                char_in_vld;
  logic                eop;
  logic [1:0]          enable;
  scan_pkg::count_t    count_gopher;
  scan_pkg::count_t    count_finger;
  logic [1:0]          fired;

  integer seed = 32'hbf22;
  int     cycle_count = 0;
  // Reference model with prefix progress per stream and keyword and expected counts
  string  keywords [2] = '{"gopher", "finger"};
  int     saved [0:(1 << STREAM_W) - 1][2];
  int     exp_count [2] = '{0, 0};
  int     streams_used [4] = '{1, 3, 5, 7};
  string  frags [6] = '{"gopher", "finger", "gop", "her", "fing", "er"};

  tb_clock_gen clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  content_scanner_top #(
    .STREAM_W (STREAM_W)
  ) dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .eop           (eop),
    .enable        (enable),
    .count_gopher  (count_gopher),
    .count_finger  (count_finger),
    .fired         (fired)
  );

  bind content_scanner_top scanner_checker u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_state   (load_state),
    .eop          (eop),
    .enable       (enable),
    .count_gopher (count_gopher),
    .count_finger (count_finger),
    .fired        (fired)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp)
    else stop_with_failure($sformatf("[FAIL] %s = %h, expected %h", name, got, exp));
  endtask

  // Keyword progress after one byte
  // A mismatch on the first letter restarts at one
  function automatic int advance_prefix(input int prog, input byte c, input string kw);
    int next;
    if (prog < kw.len() && c == kw[prog])
      next = prog + 1;
    else if (c == kw[0])
      next = 1;
    else
      next = 0;
    return next;
  endfunction

  // Letters a, b and z never touch either keyword
  function automatic string filler(input int n);
    string s;
    int    i;
    int    pick;
    s = "";
    for (i = 0; i < n; i++)
    begin
      pick = {$random(seed)} % 3;
      s = {s, (pick == 0) ? "a" : (pick == 1) ? "b" : "z"};
    end
    return s;
  endfunction

  task automatic send_packet(input int stream, input bit is_new, input string payload,
                             input bit [1:0] en);
    int i;
    int k;
    int prog [2];
    bit hit [2];
    for (k = 0; k < 2; k++)
    begin
      prog[k] = is_new ? 0 : saved[stream][k];
      hit[k]  = 1'b0;
    end
    load_state    = 1'b1;
    new_stream_id = is_new;
    stream_id     = stream[STREAM_W-1:0];
    @(posedge clk);
    #1;
    load_state    = 1'b0;
    new_stream_id = 1'b0;
    // One byte per cycle from the cycle after load_state
    for (i = 0; i < payload.len(); i++)
    begin
      char_in     = payload[i];
      char_in_vld = 1'b1;
      for (k = 0; k < 2; k++)
      begin
        prog[k] = advance_prefix(prog[k], payload[i], keywords[k]);
        if (prog[k] == keywords[k].len())
          hit[k] = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    char_in_vld = 1'b0;
    // eop four cycles after the last byte
    repeat (3) @(posedge clk);
    #1;
    eop    = 1'b1;
    enable = en;
    @(posedge clk);
    #1;
    eop    = 1'b0;
    enable = 2'b00;
    for (k = 0; k < 2; k++)
    begin
      if (en[k])
      begin
        exp_count[k] += hit[k];
        saved[stream][k] = prog[k];
      end
    end
    @(posedge clk);
    #1;
    check_value("count_gopher", count_gopher, exp_count[0]);
    check_value("count_finger", count_finger, exp_count[1]);
  endtask

  // Run limit and checker watch
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_with_failure("Timeout: the tests did not finish within the cycle limit");
    if (dut0.u_chk.error_count != 0)
      stop_with_failure("A protocol or counter assertion in the checker failed");
  end

  initial
  begin
    int p;
    int n_head;
    int n_tail;
    load_state    = 1'b0;
    new_stream_id = 1'b0;
    stream_id     = '0;
    char_in       = '0;
    char_in_vld   = 1'b0;
    eop           = 1'b0;
    enable        = 2'b00;
    wait (rst_n);
    check_value("count_gopher", count_gopher, 16'h0);
    check_value("count_finger", count_finger, 16'h0);
    check_value("fired", {14'h0, fired}, 16'h0);
    // Repeated keyword counts once per packet
    send_packet(1, 1'b1, {filler(3), "gopher", filler(2), "finger", "gopher", filler(4)}, 2'b11);
    send_packet(1, 1'b0, filler(12), 2'b11);
    // Split across packets of stream 3, then the same split broken by a new stream
    send_packet(3, 1'b1, {filler(5), "gop"}, 2'b11);
    send_packet(3, 1'b0, {"her", filler(5)}, 2'b11);
    send_packet(3, 1'b0, {filler(4), "gop"}, 2'b11);
    send_packet(3, 1'b1, {"her", filler(3)}, 2'b11);
    // Interleaved partial keywords on streams 3 and 7
    send_packet(3, 1'b0, {filler(2), "fin"}, 2'b11);
    send_packet(7, 1'b1, {filler(3), "fing"}, 2'b11);
    send_packet(3, 1'b0, {"ger", filler(2)}, 2'b11);
    send_packet(7, 1'b0, {"er", filler(2)}, 2'b11);
    // Gopher disabled, finger keeps counting
    send_packet(5, 1'b1, filler(6), 2'b11);
    send_packet(5, 1'b0, {filler(2), "gopher", "finger", "go"}, 2'b10);
    send_packet(5, 1'b0, {"pher", filler(2), "finger"}, 2'b11);
    // Random mix of fragments on the streams seen so far
    for (p = 0; p < RAND_PACKETS; p++)
    begin
      n_head = {$random(seed)} % 16;
      n_tail = {$random(seed)} % 8;
      send_packet(streams_used[{$random(seed)} % 4], ({$random(seed)} % 4) == 0,
                  {filler(n_head), frags[{$random(seed)} % 6], filler(n_tail)},
                  2'($random(seed)));
    end
    if (dut0.u_chk.error_count != 0)
      stop_with_failure("A protocol or counter assertion in the checker failed");
    else
    begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 10,
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock, first rising edge at half a period
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset released just after an edge, like the other stimulus
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule
